/* rv32_macros.svh */
// Widths for the RV32I integer pipeline; only XLEN 32 with 32 registers is supported
`ifndef RV32_MACROS_SVH
`define RV32_MACROS_SVH

// Data and PC width
`define RV32_XLEN 32

// Architectural register count
`define RV32_REGS 32

`endif

/* rv32_pkg.sv */
// RV32I pipeline types; opcodes cover the base integer set only, no CSR, FENCE or system ops
`include "rv32_macros.svh"

package rv32_pkg;

    typedef logic [`RV32_XLEN-1:0] word_t;
    typedef logic [$clog2(`RV32_REGS)-1:0] reg_addr_t;

    // Major opcodes, bits 6:0 of the instruction
    typedef enum logic [6:0] {
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011
    } opcode_e;

    // NULL must stay zero, it is the reset value of a record
    typedef enum logic [3:0] {
        NULL,
        INTEGER,
        JUMP,
        BRANCH,
        LOAD_BYTE,
        LOAD_HALF,
        LOAD_WORD,
        LOAD_BYTE_UNSIGNED,
        LOAD_HALF_UNSIGNED,
        STORE_BYTE,
        STORE_HALF,
        STORE_WORD,
        INVALID
    } op_e;

    typedef enum logic [3:0] {
        ADD, SUB, SLT, SLTU, AND, OR, XOR, SLL, SRL, SRA, OP2
    } fun_e;

    typedef enum logic [2:0] {
        NONE, JAL_JALR, BEQ, BNE, BLT, BGE, BLTU, BGEU
    } br_e;

    typedef enum logic {RS1, PC} op1_sel_e;

    typedef enum logic [2:0] {RS2, I_IMM, S_IMM, B_IMM, U_IMM, J_IMM} op2_sel_e;

    typedef enum logic [1:0] {REG, ALU, EXE} fwd_sel_e;

    // Instruction formats, most significant field first
    typedef struct packed {
        logic [6:0] funct7;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        reg_addr_t  rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        reg_addr_t   rs1;
        logic [2:0]  funct3;
        reg_addr_t   rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        reg_addr_t   rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        reg_addr_t  rd;
        logic [6:0] opcode;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } inst_u;

    typedef struct packed {
        word_t pc;
        inst_u ir;
    } inst_beat_t;

    typedef struct packed {
        op_e      op;
        fun_e     fun;
        br_e      br;
        op1_sel_e op1;
        op2_sel_e op2;
    } ctrl_t;

    // rs1 travels beside op1 since branches put the PC in op1
    typedef struct packed {
        op_e       op;
        fun_e      fun;
        br_e       br;
        word_t     pc;
        word_t     op1;
        word_t     op2;
        word_t     rs1;
        word_t     rs2;
        reg_addr_t rd;
    } ex_beat_t;

    typedef struct packed {
        op_e       op;
        reg_addr_t rd;
        word_t     value;
        word_t     store_data;
        logic      taken;
        word_t     target;
    } result_t;

endpackage

/* register_file.sv */
// Two asynchronous reads and one synchronous write; x0 reads as zero and ignores writes
`include "rv32_macros.svh"

module rv32_register_file (
    input  logic                sink,
    input  logic                reset,
    input  rv32_pkg::reg_addr_t rs1_addr,
    input  rv32_pkg::reg_addr_t rs2_addr,
    input  logic                wr_en,
    input  rv32_pkg::reg_addr_t wr_addr,
    input  rv32_pkg::word_t     wr_data,
    output rv32_pkg::word_t     rs1_data,
    output rv32_pkg::word_t     rs2_data
);
    rv32_pkg::word_t regs [`RV32_REGS];

    always_ff @(posedge sink) begin
        if (reset) begin
            for (int i = 0; i < `RV32_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_addr != '0) begin
            regs[wr_addr] <= wr_data;
        end
    end

    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

/* forward_unit.sv */
// Forwarding from execute and result stages only; callers qualify the writes flags
module rv32_forward_unit (
    input  rv32_pkg::reg_addr_t rs1_addr,
    input  rv32_pkg::reg_addr_t rs2_addr,
    input  rv32_pkg::reg_addr_t ex_rd,
    input  logic                ex_writes,
    input  rv32_pkg::reg_addr_t res_rd,
    input  logic                res_writes,
    output rv32_pkg::fwd_sel_e  rs1_sel,
    output rv32_pkg::fwd_sel_e  rs2_sel
);
    // Nearer stage holds the younger value, so it wins
    function automatic rv32_pkg::fwd_sel_e sel_for(rv32_pkg::reg_addr_t addr);
        if (addr == '0) begin
            return rv32_pkg::REG;
        end
        if (ex_writes && ex_rd == addr) begin
            return rv32_pkg::ALU;
        end
        if (res_writes && res_rd == addr) begin
            return rv32_pkg::EXE;
        end
        return rv32_pkg::REG;
    endfunction

    assign rs1_sel = sel_for(rs1_addr);
    assign rs2_sel = sel_for(rs2_addr);

endmodule

/* decode_stage.sv */
// Decodes RV32I base integer encodings only; anything else becomes an INVALID record
`include "rv32_macros.svh"

module rv32_decode_stage (
    input  logic                 sink,
    input  logic                 reset,
    input  rv32_pkg::inst_beat_t inst,
    input  logic                 inst_valid,
    input  logic                 advance,
    input  rv32_pkg::fwd_sel_e   rs1_sel,
    input  rv32_pkg::fwd_sel_e   rs2_sel,
    input  rv32_pkg::word_t      rs1_data,
    input  rv32_pkg::word_t      rs2_data,
    input  rv32_pkg::word_t      alu_data,
    input  rv32_pkg::word_t      exe_data,
    output rv32_pkg::reg_addr_t  rs1_addr,
    output rv32_pkg::reg_addr_t  rs2_addr,
    output rv32_pkg::ex_beat_t   ex,
    output logic                 ex_valid
);
    localparam rv32_pkg::ctrl_t INVAL = '{
        op:  rv32_pkg::INVALID,
        fun: rv32_pkg::ADD,
        br:  rv32_pkg::NONE,
        op1: rv32_pkg::RS1,
        op2: rv32_pkg::RS2
    };

    function automatic rv32_pkg::ctrl_t mk(
        rv32_pkg::op_e      op,
        rv32_pkg::fun_e     fun,
        rv32_pkg::br_e      br,
        rv32_pkg::op1_sel_e op1,
        rv32_pkg::op2_sel_e op2
    );
        return '{op: op, fun: fun, br: br, op1: op1, op2: op2};
    endfunction

    function automatic rv32_pkg::word_t pick(rv32_pkg::fwd_sel_e sel, rv32_pkg::word_t rf);
        case (sel)
            rv32_pkg::ALU: return alu_data;
            rv32_pkg::EXE: return exe_data;
            default:       return rf;
        endcase
    endfunction

    rv32_pkg::inst_u   ir;
    rv32_pkg::ctrl_t   ctrl;
    rv32_pkg::fun_e    arith;
    rv32_pkg::word_t   i_imm, s_imm, b_imm, u_imm, j_imm;
    rv32_pkg::word_t   rs1, rs2, op1, op2;

    assign ir       = inst.ir;
    assign rs1_addr = ir.r.rs1;
    assign rs2_addr = ir.r.rs2;

    assign i_imm = {{(`RV32_XLEN-12){ir.i.imm_11_0[11]}}, ir.i.imm_11_0};
    assign s_imm = {{(`RV32_XLEN-12){ir.s.imm_11_5[6]}}, ir.s.imm_11_5, ir.s.imm_4_0};
    assign b_imm = {{(`RV32_XLEN-13){ir.b.imm_12}}, ir.b.imm_12, ir.b.imm_11,
                    ir.b.imm_10_5, ir.b.imm_4_1, 1'b0};
    assign u_imm = {ir.u.imm_31_12, 12'd0};
    assign j_imm = {{(`RV32_XLEN-21){ir.j.imm_20}}, ir.j.imm_20, ir.j.imm_19_12,
                    ir.j.imm_11, ir.j.imm_10_1, 1'b0};

    // ALU function from funct3, shared by OP and OP_IMM
    always_comb begin
        case (ir.r.funct3)
            3'b000: begin
                // SUB exists only in register form
                arith = (ir.r.opcode == rv32_pkg::OPC_OP && ir.r.funct7[5]) ?
                        rv32_pkg::SUB : rv32_pkg::ADD;
            end
            3'b001:  arith = rv32_pkg::SLL;
            3'b010:  arith = rv32_pkg::SLT;
            3'b011:  arith = rv32_pkg::SLTU;
            3'b100:  arith = rv32_pkg::XOR;
            3'b101:  arith = ir.r.funct7[5] ? rv32_pkg::SRA : rv32_pkg::SRL;
            3'b110:  arith = rv32_pkg::OR;
            default: arith = rv32_pkg::AND;
        endcase
    end

    always_comb begin
        ctrl = INVAL;
        case (ir.r.opcode)
            rv32_pkg::OPC_OP_IMM:
                ctrl = mk(rv32_pkg::INTEGER, arith, rv32_pkg::NONE, rv32_pkg::RS1,
                          rv32_pkg::I_IMM);
            rv32_pkg::OPC_OP:
                ctrl = mk(rv32_pkg::INTEGER, arith, rv32_pkg::NONE, rv32_pkg::RS1,
                          rv32_pkg::RS2);
            rv32_pkg::OPC_LUI:
                ctrl = mk(rv32_pkg::INTEGER, rv32_pkg::OP2, rv32_pkg::NONE, rv32_pkg::RS1,
                          rv32_pkg::U_IMM);
            rv32_pkg::OPC_AUIPC:
                ctrl = mk(rv32_pkg::INTEGER, rv32_pkg::ADD, rv32_pkg::NONE, rv32_pkg::PC,
                          rv32_pkg::U_IMM);
            rv32_pkg::OPC_JAL:
                ctrl = mk(rv32_pkg::JUMP, rv32_pkg::ADD, rv32_pkg::JAL_JALR, rv32_pkg::PC,
                          rv32_pkg::J_IMM);
            rv32_pkg::OPC_JALR: begin
                if (ir.i.funct3 == 3'b000) begin
                    ctrl = mk(rv32_pkg::JUMP, rv32_pkg::ADD, rv32_pkg::JAL_JALR,
                              rv32_pkg::RS1, rv32_pkg::I_IMM);
                end
            end
            rv32_pkg::OPC_BRANCH: begin
                ctrl = mk(rv32_pkg::BRANCH, rv32_pkg::ADD, rv32_pkg::NONE, rv32_pkg::PC,
                          rv32_pkg::B_IMM);
                case (ir.b.funct3)
                    3'b000:  ctrl.br = rv32_pkg::BEQ;
                    3'b001:  ctrl.br = rv32_pkg::BNE;
                    3'b100:  ctrl.br = rv32_pkg::BLT;
                    3'b101:  ctrl.br = rv32_pkg::BGE;
                    3'b110:  ctrl.br = rv32_pkg::BLTU;
                    3'b111:  ctrl.br = rv32_pkg::BGEU;
                    default: ctrl = INVAL;
                endcase
            end
            rv32_pkg::OPC_LOAD: begin
                ctrl = mk(rv32_pkg::LOAD_WORD, rv32_pkg::ADD, rv32_pkg::NONE, rv32_pkg::RS1,
                          rv32_pkg::I_IMM);
                case (ir.i.funct3)
                    3'b000:  ctrl.op = rv32_pkg::LOAD_BYTE;
                    3'b001:  ctrl.op = rv32_pkg::LOAD_HALF;
                    3'b010:  ctrl.op = rv32_pkg::LOAD_WORD;
                    3'b100:  ctrl.op = rv32_pkg::LOAD_BYTE_UNSIGNED;
                    3'b101:  ctrl.op = rv32_pkg::LOAD_HALF_UNSIGNED;
                    default: ctrl = INVAL;
                endcase
            end
            rv32_pkg::OPC_STORE: begin
                ctrl = mk(rv32_pkg::STORE_WORD, rv32_pkg::ADD, rv32_pkg::NONE, rv32_pkg::RS1,
                          rv32_pkg::S_IMM);
                case (ir.s.funct3)
                    3'b000:  ctrl.op = rv32_pkg::STORE_BYTE;
                    3'b001:  ctrl.op = rv32_pkg::STORE_HALF;
                    3'b010:  ctrl.op = rv32_pkg::STORE_WORD;
                    default: ctrl = INVAL;
                endcase
            end
            default: ;
        endcase
    end

    assign rs1 = pick(rs1_sel, rs1_data);
    assign rs2 = pick(rs2_sel, rs2_data);
    assign op1 = (ctrl.op1 == rv32_pkg::PC) ? inst.pc : rs1;

    always_comb begin
        case (ctrl.op2)
            rv32_pkg::I_IMM: op2 = i_imm;
            rv32_pkg::S_IMM: op2 = s_imm;
            rv32_pkg::B_IMM: op2 = b_imm;
            rv32_pkg::U_IMM: op2 = u_imm;
            rv32_pkg::J_IMM: op2 = j_imm;
            default:         op2 = rs2;
        endcase
    end

    always_ff @(posedge sink) begin
        if (reset) begin
            ex       <= '0;
            ex_valid <= 1'b0;
        end else if (advance) begin
            ex.op    <= ctrl.op;
            ex.fun   <= ctrl.fun;
            ex.br    <= ctrl.br;
            ex.pc    <= inst.pc;
            ex.op1   <= op1;
            ex.op2   <= op2;
            ex.rs1   <= rs1;
            ex.rs2   <= rs2;
            ex.rd    <= ir.r.rd;
            ex_valid <= inst_valid;
        end
    end

endmodule

/* execute_stage.sv */
// Branches only report taken and target; loads and stores only report address and data
`include "rv32_macros.svh"

module rv32_execute_stage (
    input  logic               sink,
    input  logic               reset,
    input  rv32_pkg::ex_beat_t ex,
    input  logic               ex_valid,
    input  logic               advance,
    output rv32_pkg::word_t    alu_data,
    output rv32_pkg::result_t  result,
    output logic               result_valid
);
    rv32_pkg::word_t   alu;
    rv32_pkg::result_t res_next;
    logic [$clog2(`RV32_XLEN)-1:0] shamt;

    assign shamt = ex.op2[$clog2(`RV32_XLEN)-1:0];

    always_comb begin
        case (ex.fun)
            rv32_pkg::ADD:  alu = ex.op1 + ex.op2;
            rv32_pkg::SUB:  alu = ex.op1 - ex.op2;
            rv32_pkg::SLT:  alu = rv32_pkg::word_t'($signed(ex.op1) < $signed(ex.op2));
            rv32_pkg::SLTU: alu = rv32_pkg::word_t'(ex.op1 < ex.op2);
            rv32_pkg::AND:  alu = ex.op1 & ex.op2;
            rv32_pkg::OR:   alu = ex.op1 | ex.op2;
            rv32_pkg::XOR:  alu = ex.op1 ^ ex.op2;
            rv32_pkg::SLL:  alu = ex.op1 << shamt;
            rv32_pkg::SRL:  alu = ex.op1 >> shamt;
            rv32_pkg::SRA:  alu = $signed(ex.op1) >>> shamt;
            default:        alu = ex.op2;
        endcase
    end

    always_comb begin
        res_next.op = ex.op;
        res_next.rd = ex.rd;
        // Jumps link to the next sequential PC
        res_next.value = (ex.op == rv32_pkg::JUMP) ? ex.pc + 4 : alu;
        res_next.store_data = '0;
        if (ex.op inside {rv32_pkg::STORE_BYTE, rv32_pkg::STORE_HALF, rv32_pkg::STORE_WORD}) begin
            res_next.store_data = ex.rs2;
        end
        case (ex.br)
            rv32_pkg::JAL_JALR: res_next.taken = 1'b1;
            rv32_pkg::BEQ:      res_next.taken = ex.rs1 == ex.rs2;
            rv32_pkg::BNE:      res_next.taken = ex.rs1 != ex.rs2;
            rv32_pkg::BLT:      res_next.taken = $signed(ex.rs1) < $signed(ex.rs2);
            rv32_pkg::BGE:      res_next.taken = $signed(ex.rs1) >= $signed(ex.rs2);
            rv32_pkg::BLTU:     res_next.taken = ex.rs1 < ex.rs2;
            rv32_pkg::BGEU:     res_next.taken = ex.rs1 >= ex.rs2;
            default:            res_next.taken = 1'b0;
        endcase
        // Target is pc+imm or rs1+imm, bit 0 cleared for JALR
        res_next.target = (ex.br == rv32_pkg::NONE) ? '0 : {alu[`RV32_XLEN-1:1], 1'b0};
    end

    // Value that will be written back, seen by decode a cycle early
    assign alu_data = res_next.value;

    always_ff @(posedge sink) begin
        if (reset) begin
            result       <= '0;
            result_valid <= 1'b0;
        end else if (advance) begin
            result       <= res_next;
            result_valid <= ex_valid;
        end
    end

endmodule

/* int_pipeline.sv */
// Two-stage RV32I decode/execute; the whole pipe stalls while a result waits on result_ready
module int_pipeline (
    input  logic                 sink,
    input  logic                 reset,
    input  rv32_pkg::inst_beat_t inst,
    input  logic                 inst_valid,
    output logic                 inst_ready,
    output rv32_pkg::result_t    result,
    output logic                 result_valid,
    input  logic                 result_ready
);
    logic                advance;
    logic                ex_valid;
    logic                ex_writes;
    logic                res_writes;
    logic                wr_en;
    rv32_pkg::ex_beat_t  ex;
    rv32_pkg::reg_addr_t rs1_addr, rs2_addr;
    rv32_pkg::word_t     rs1_data, rs2_data;
    rv32_pkg::word_t     alu_data;
    rv32_pkg::fwd_sel_e  rs1_sel, rs2_sel;

    assign advance    = result_ready || !result_valid;
    assign inst_ready = advance;

    // Only integer ops and jumps write rd
    assign ex_writes  = ex_valid && (ex.op == rv32_pkg::INTEGER || ex.op == rv32_pkg::JUMP);
    assign res_writes = result_valid &&
                        (result.op == rv32_pkg::INTEGER || result.op == rv32_pkg::JUMP);
    assign wr_en      = res_writes && result_ready && result.rd != '0;

    rv32_decode_stage decode_i (
        .sink       (sink),
        .reset      (reset),
        .inst       (inst),
        .inst_valid (inst_valid),
        .advance    (advance),
        .rs1_sel    (rs1_sel),
        .rs2_sel    (rs2_sel),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .alu_data   (alu_data),
        .exe_data   (result.value),
        .rs1_addr   (rs1_addr),
        .rs2_addr   (rs2_addr),
        .ex         (ex),
        .ex_valid   (ex_valid)
    );

    rv32_register_file regfile_i (
        .sink     (sink),
        .reset    (reset),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .wr_en    (wr_en),
        .wr_addr  (result.rd),
        .wr_data  (result.value),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    rv32_forward_unit forward_i (
        .rs1_addr   (rs1_addr),
        .rs2_addr   (rs2_addr),
        .ex_rd      (ex.rd),
        .ex_writes  (ex_writes),
        .res_rd     (result.rd),
        .res_writes (res_writes),
        .rs1_sel    (rs1_sel),
        .rs2_sel    (rs2_sel)
    );

    rv32_execute_stage execute_i (
        .sink         (sink),
        .reset        (reset),
        .ex           (ex),
        .ex_valid     (ex_valid),
        .advance      (advance),
        .alu_data     (alu_data),
        .result       (result),
        .result_valid (result_valid)
    );

endmodule

/* int_pipeline_tb.sv */
// Reads int_pipeline_trace.txt from the working directory; results must arrive in trace order
module int_pipeline_tb;

    logic                 sink;
    logic                 reset;
    rv32_pkg::inst_beat_t inst;
    logic                 inst_valid;
    logic                 inst_ready;
    rv32_pkg::result_t    result;
    logic                 result_valid;
    logic                 result_ready;

    string                names[$];
    rv32_pkg::inst_beat_t beats[$];
    rv32_pkg::result_t    expects[$];
    int                   acc_cycle[$];
    // Set when no stall followed the acceptance
    bit                   clean[$];

    int          n_tests;
    int          sent;
    int          got;
    int          passed;
    int          failed;
    int          errors;
    bit          test_bad;
    logic [31:0] rng;

    int_pipeline dut_i (
        .sink         (sink),
        .reset        (reset),
        .inst         (inst),
        .inst_valid   (inst_valid),
        .inst_ready   (inst_ready),
        .result       (result),
        .result_valid (result_valid),
        .result_ready (result_ready)
    );

    initial begin
        sink = 1'b0;
        forever #50 sink = ~sink;
    end

    function automatic logic [31:0] next_rand();
        rng = rng * 32'd1664525 + 32'd1013904223;
        return rng;
    endfunction

    task automatic load_trace();
        int                   fd;
        int                   code;
        string                line;
        string                name;
        logic [31:0]          pc_v, ir_v, op_v, rd_v, val_v, sd_v, tk_v, tg_v;
        rv32_pkg::inst_beat_t beat;
        rv32_pkg::result_t    exp;
        fd = $fopen("int_pipeline_trace.txt", "r");
        if (fd == 0) begin
            return;
        end
        while (!$feof(fd)) begin
            code = $fgets(line, fd);
            if (code == 0 || line.len() == 0 || line.getc(0) == "#") begin
                continue;
            end
            code = $sscanf(line, "%s %h %h %h %h %h %h %h %h", name, pc_v, ir_v, op_v,
                           rd_v, val_v, sd_v, tk_v, tg_v);
            if (code <= 0) begin
                continue;
            end
            if (code != 9) begin
                $display("Malformed trace line: %s", line);
                errors++;
                continue;
            end
            beat.pc = pc_v;
            beat.ir = rv32_pkg::inst_u'(ir_v);
            exp.op = rv32_pkg::op_e'(op_v[3:0]);
            exp.rd = rd_v[4:0];
            exp.value = val_v;
            exp.store_data = sd_v;
            exp.taken = tk_v[0];
            exp.target = tg_v;
            names.push_back(name);
            beats.push_back(beat);
            expects.push_back(exp);
        end
        $fclose(fd);
        n_tests = names.size();
    endtask

    task automatic compare_op(string name, rv32_pkg::op_e exp, rv32_pkg::op_e act);
        if (act !== exp) begin
            $display("[ERROR] %s op: expected %s, actual %s (%0d)", name, exp.name(),
                     act.name(), act);
            test_bad = 1'b1;
        end
    endtask

    task automatic compare_word(string name, string field, rv32_pkg::word_t exp,
                                rv32_pkg::word_t act);
        if (act !== exp) begin
            $display("[ERROR] %s %s: expected %h, actual %h", name, field, exp, act);
            test_bad = 1'b1;
        end
    endtask

    task automatic compare_result(string name, rv32_pkg::result_t exp, rv32_pkg::result_t act);
        compare_op(name, exp.op, act.op);
        compare_word(name, "rd", rv32_pkg::word_t'(exp.rd), rv32_pkg::word_t'(act.rd));
        compare_word(name, "value", exp.value, act.value);
        compare_word(name, "store_data", exp.store_data, act.store_data);
        compare_word(name, "taken", rv32_pkg::word_t'(exp.taken), rv32_pkg::word_t'(act.taken));
        compare_word(name, "target", exp.target, act.target);
    endtask

    task automatic compare_latency(string name, int exp, int act);
        if (act != exp) begin
            $display("[ERROR] %s latency: expected cycle %0d, actual cycle %0d", name, exp, act);
            test_bad = 1'b1;
        end
    endtask

    task automatic finish_test(int k, int shown_cycle);
        test_bad = 1'b0;
        compare_result(names[k], expects[k], result);
        if (clean[k]) begin
            compare_latency(names[k], acc_cycle[k] + 2, shown_cycle);
        end
        if (test_bad) begin
            $display("FAIL %s", names[k]);
            failed++;
        end else begin
            $display("PASS %s", names[k]);
            passed++;
        end
    endtask

    initial begin
        int cycle;
        int shown_cycle;
        bit shown;
        bit beat_taken;
        bit adv;
        reset = 1'b1;
        inst = '0;
        inst_valid = 1'b0;
        result_ready = 1'b0;
        rng = 32'h74f4_ca50;
        cycle = 0;
        shown = 1'b0;
        shown_cycle = 0;
        beat_taken = 1'b0;
        load_trace();
        if (n_tests == 0) begin
            $display("Trace file could not be read or holds no tests");
            errors++;
        end
        repeat (10) @(negedge sink);
        reset = 1'b0;
        while (got < n_tests) begin
            @(negedge sink);
            cycle++;
            if (beat_taken) begin
                inst_valid = 1'b0;
            end
            // Gap of one cycle about a quarter of the time
            if (!inst_valid && sent < n_tests && next_rand() >= 32'h4000_0000) begin
                inst = beats[sent];
                inst_valid = 1'b1;
            end
            result_ready = next_rand() >= 32'h4000_0000;
            #1;
            adv = result_ready || !result_valid;
            if (inst_ready !== adv) begin
                $display("inst_ready does not follow result back-pressure in cycle %0d", cycle);
                errors++;
            end
            if (sent > 0 && acc_cycle[sent-1] == cycle - 1) begin
                clean[sent-1] = adv;
            end
            if (result_valid && got >= sent) begin
                $display("A result appeared with no instruction outstanding in cycle %0d", cycle);
                errors++;
            end else if (result_valid) begin
                if (!shown) begin
                    shown = 1'b1;
                    shown_cycle = cycle;
                end
                if (result_ready) begin
                    finish_test(got, shown_cycle);
                    got++;
                    shown = 1'b0;
                end
            end
            beat_taken = inst_valid && inst_ready;
            if (beat_taken) begin
                acc_cycle.push_back(cycle);
                clean.push_back(1'b0);
                sent++;
            end
        end
        $display("Tests %0d, passed %0d, failed %0d, other errors %0d", n_tests, passed,
                 failed, errors);
        if (failed == 0 && errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    // Watchdog sized from the trace length
    initial begin
        wait (n_tests > 0);
        repeat (10 + n_tests * 20) @(posedge sink);
        $display("Timeout: test %s never completed", names[got]);
        $display("Finished with errors");
        $finish;
    end

endmodule

/* int_pipeline.f */
+incdir+.
rv32_pkg.sv
register_file.sv
forward_unit.sv
decode_stage.sv
execute_stage.sv
int_pipeline.sv
int_pipeline_tb.sv

/* run.sh */
#!/bin/sh
# Build with Verilator from the project root, run, and look for the pass line
verilator --binary --timing -f int_pipeline.f --top-module int_pipeline_tb \
        -o int_pipeline_sim &&
    out=$(./obj_dir/int_pipeline_sim) &&
    printf '%s\n' "$out" &&
    printf '%s\n' "$out" | grep -qx "Finished with no errors" ||
    { echo "Simulation did not pass"; exit 1; }

/* int_pipeline_trace.txt */
# name pc inst | expected result: op rd value store_data taken target, all hex
# op: 1 INTEGER, 2 JUMP, 3 BRANCH, 6 LOAD_WORD, 9 STORE_BYTE, c INVALID
addi_imm      00000100 12300093 1 01 00000123 00000000 0 00000000
addi_fwd_alu  00000104 fff08113 1 02 00000122 00000000 0 00000000
lui_upper     00000108 800001b7 1 03 80000000 00000000 0 00000000
add_fwd_exe   0000010c 00208233 1 04 00000245 00000000 0 00000000
sub_wrap      00000110 401182b3 1 05 7ffffedd 00000000 0 00000000
srai_sign     00000114 4041d313 1 06 f8000000 00000000 0 00000000
srli_zero     00000118 0041d393 1 07 08000000 00000000 0 00000000
slt_signed    0000011c 0011a433 1 08 00000001 00000000 0 00000000
sltu_unsigned 00000120 0011b4b3 1 09 00000000 00000000 0 00000000
andi_mask     00000124 0ff2f513 1 0a 000000dd 00000000 0 00000000
or_reg        00000128 007565b3 1 0b 080000dd 00000000 0 00000000
xor_reg       0000012c 0015c633 1 0c 080001fe 00000000 0 00000000
slli_shift    00000130 00809693 1 0d 00012300 00000000 0 00000000
addi_to_x0    00000134 00508013 1 00 00000128 00000000 0 00000000
x0_reads_zero 00000138 00700713 1 0e 00000007 00000000 0 00000000
auipc_pc      0000013c 12345797 1 0f 1234513c 00000000 0 00000000
beq_taken     00000140 00108863 3 10 00000150 00000000 1 00000150
bne_backward  00000144 fe209ce3 3 19 0000013c 00000000 1 0000013c
blt_taken     00000148 0011c463 3 08 00000150 00000000 1 00000150
bltu_not      0000014c 0011e463 3 08 00000154 00000000 0 00000154
bge_taken     00000150 0030d463 3 08 00000158 00000000 1 00000158
bgeu_not      00000154 0030f463 3 08 0000015c 00000000 0 0000015c
jal_link      00000158 0200086f 2 10 0000015c 00000000 1 00000178
jalr_link     0000015c 003808e7 2 11 00000160 00000000 1 0000015e
lw_address    00000160 ffc6a083 6 01 000122fc 00000000 0 00000000
sb_old_rd     00000164 00c082a3 9 05 00000128 080001fe 0 00000000
bad_opcode    00000168 000002ff c 05 00000000 00000000 0 00000000
bad_funct3    0000016c 00002363 c 06 00000000 00000000 0 00000000
add_kept_regs 00000170 00628933 1 12 77fffedd 00000000 0 00000000
